// ==== list.f ====
+incdir+rtl
rtl/apb_pkg.sv
rtl/apb_wait_timer.sv
rtl/apb_master.sv
rtl/apb_addr_map.sv
rtl/apb_reg_bank.sv
rtl/apb_subsystem_top.sv
tb/tb_apb_subsystem.sv

// ==== tb/tb_apb_subsystem.sv ====
`timescale 1ns/1ps
`include "apb_defines.svh"

module tb_apb_subsystem;
    import apb_pkg::*;

    localparam time CLK_PERIOD     = 10;
    localparam int  TRANSFER_LIMIT = 20;
    // about 205 transfers of at most 6 cycles, plus margin for reset and test 5
    localparam int  N_TRANSFERS    = 230;
    localparam int  MAX_CYCLES     = 6;
    localparam time WATCHDOG_NS    = N_TRANSFERS * MAX_CYCLES * CLK_PERIOD + 6200;
    localparam logic [31:0] WIN_BASE = `APB_WIN_BASE;

    logic                   PCLK;
    logic                   PRESET;
    logic                   transfer;
    apb_req_t               req;
    logic                   ready;
    logic [`APB_DATA_W-1:0] rdata;
    logic                   err;

    logic [31:0] model [`APB_NUM_SLOTS][`APB_BANK_DEPTH];
    integer      seed;
    int          pass_count;
    int          fail_count;

    apb_subsystem_top UUT (
        .PCLK    (PCLK),
        .PRESET  (PRESET),
        .transfer(transfer),
        .req     (req),
        .ready   (ready),
        .rdata   (rdata),
        .err     (err)
    );

    initial begin
        PCLK = 1'b0;
        forever #(CLK_PERIOD / 2) PCLK = ~PCLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0t, the tests did not finish in time", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    function automatic logic [31:0] slot_addr(input int slot, input int off);
        return WIN_BASE | (slot << 12) | (off << 2);
    endfunction

    // called 1 ns after an edge; latency counts edges from that edge to ready
    task automatic do_transfer(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic write, output logic [31:0] rd,
                               output logic er, output int lat);
        int edges;
        req.addr  = addr;
        req.wdata = wdata;
        req.write = write;
        transfer  = 1'b1;
        edges     = 0;
        rd        = '0;
        er        = 1'b0;
        lat       = -1;
        while (lat < 0 && edges < TRANSFER_LIMIT) begin
            @(posedge PCLK);
            #1;
            edges++;
            if (edges == 1) begin
                transfer = 1'b0;
            end
            if (ready) begin
                lat = edges;
                rd  = rdata;
                er  = err;
            end
        end
        if (lat < 0) begin
            $display("no ready pulse within %0d cycles of the transfer to %h",
                     TRANSFER_LIMIT, addr);
            fail_count++;
        end
    endtask

    // expected response comes from the address map rules and the model
    task automatic access_and_check(input logic [31:0] addr, input logic [31:0] wdata,
                                    input logic write);
        logic [31:0] rd;
        logic        er;
        int          lat;
        logic        in_win;
        int          slot;
        int          off;
        in_win = (addr[31:14] == WIN_BASE[31:14]);
        slot   = addr[13:12];
        off    = addr[5:2];
        do_transfer(addr, wdata, write, rd, er, lat);
        if (!in_win) begin
            check_value("err", 32'd1, {31'd0, er});
            check_value("rdata", 32'd0, rd);
            check_value("latency", 32'd3, lat);
        end else begin
            check_value("err", 32'd0, {31'd0, er});
            check_value("rdata", write ? 32'd0 : model[slot][off], rd);
            check_value("latency", 3 + slot, lat);
            if (write) begin
                model[slot][off] = wdata;
            end
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %s finished with %0d errors", name, fail_count - fails_before);
    endtask

    task automatic test_reset_state();
        int f0;
        f0 = fail_count;
        check_value("ready", 32'd0, {31'd0, ready});
        check_value("err", 32'd0, {31'd0, err});
        check_value("rdata", 32'd0, rdata);
        for (int s = 0; s < `APB_NUM_SLOTS; s++) begin
            access_and_check(slot_addr(s, 0), 32'd0, 1'b0);
        end
        report_test("reset_state", f0);
    endtask

    task automatic test_write_read();
        int f0;
        f0 = fail_count;
        // same offsets in every slot, different data per slot
        for (int s = 0; s < `APB_NUM_SLOTS; s++) begin
            for (int o = 0; o < 4; o++) begin
                access_and_check(slot_addr(s, o * 5), 32'hA500_0000 | (s << 8) | o, 1'b1);
            end
        end
        for (int s = 0; s < `APB_NUM_SLOTS; s++) begin
            for (int o = 0; o < 4; o++) begin
                access_and_check(slot_addr(s, o * 5), 32'd0, 1'b0);
            end
        end
        report_test("write_read", f0);
    endtask

    task automatic test_latency();
        int f0;
        f0 = fail_count;
        for (int s = 0; s < `APB_NUM_SLOTS; s++) begin
            access_and_check(slot_addr(s, 9), 32'h0BAD_0000 + s, 1'b1);
            access_and_check(slot_addr(s, 9), 32'd0, 1'b0);
        end
        report_test("latency", f0);
    endtask

    task automatic test_unmapped();
        int f0;
        f0 = fail_count;
        access_and_check(32'h2000_0000, 32'hDEAD_BEEF, 1'b1);
        access_and_check(32'h2000_0000, 32'd0, 1'b0);
        access_and_check(32'h1000_4000, 32'hFEED_F00D, 1'b1);
        access_and_check(32'h1000_4000, 32'd0, 1'b0);
        // offset 0 is where a bad decode would alias
        for (int s = 0; s < `APB_NUM_SLOTS; s++) begin
            access_and_check(slot_addr(s, 0), 32'd0, 1'b0);
        end
        report_test("unmapped", f0);
    endtask

    task automatic test_busy_ignore();
        int         f0;
        int         pulses;
        int         lat;
        apb_state_e st;
        f0     = fail_count;
        pulses = 0;
        lat    = -1;
        st     = IDLE;
        req.addr  = slot_addr(3, 7);
        req.wdata = 32'h3333_7777;
        req.write = 1'b1;
        transfer  = 1'b1;
        for (int cyc = 1; cyc <= 12; cyc++) begin
            @(posedge PCLK);
            #1;
            if (cyc == 1) begin
                transfer = 1'b0;
            end else if (cyc == 2) begin
                // second request while the slot 3 access is running
                req.addr  = slot_addr(0, 7);
                req.wdata = 32'h0000_9999;
                transfer  = 1'b1;
            end else if (cyc == 3) begin
                st       = UUT.u_master.state;
                transfer = 1'b0;
            end
            if (ready) begin
                pulses++;
                lat = cyc;
            end
        end
        model[3][7] = 32'h3333_7777;
        $display("extra transfer raised while the master was in %s", st.name());
        check_value("ready pulses", 32'd1, pulses);
        check_value("latency", 32'd6, lat);
        access_and_check(slot_addr(0, 7), 32'd0, 1'b0);
        access_and_check(slot_addr(3, 7), 32'd0, 1'b0);
        report_test("busy_ignore", f0);
    endtask

    task automatic test_random();
        int          f0;
        int          s;
        int          o;
        logic        wr;
        logic [31:0] data;
        f0 = fail_count;
        for (int n = 0; n < 150; n++) begin
            s    = $random(seed) & 3;
            o    = $random(seed) & 15;
            wr   = $random(seed) & 1;
            data = $random(seed);
            access_and_check(slot_addr(s, o), data, wr);
        end
        report_test("random", f0);
    endtask

    initial begin
        PRESET     = 1'b1;
        transfer   = 1'b0;
        req        = '0;
        seed       = 51100;
        pass_count = 0;
        fail_count = 0;
        for (int s = 0; s < `APB_NUM_SLOTS; s++) begin
            for (int o = 0; o < `APB_BANK_DEPTH; o++) begin
                model[s][o] = '0;
            end
        end
        repeat (8) @(posedge PCLK);
        #1;
        PRESET = 1'b0;

        test_reset_state();
        test_write_read();
        test_latency();
        test_unmapped();
        test_busy_ignore();
        test_random();

        $display("checks passed %0d, checks failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== rtl/apb_subsystem_top.sv ====
`timescale 1ns/1ps
`include "apb_defines.svh"

module apb_subsystem_top (
    input  logic                   PCLK,
    input  logic                   PRESET,
    input  logic                   transfer,
    input  apb_pkg::apb_req_t      req,
    output logic                   ready,
    output logic [`APB_DATA_W-1:0] rdata,
    output logic                   err
);
    import apb_pkg::*;

    apb_bus_t                  bus;
    apb_rsp_t                  rsp;
    apb_rsp_t                  slave_rsp [`APB_NUM_SLOTS];
    logic [`APB_NUM_SLOTS-1:0] psel;
    logic                      sel_en;
    logic                      miss;

    apb_master u_master (
        .PCLK    (PCLK),
        .PRESET  (PRESET),
        .transfer(transfer),
        .req     (req),
        .ready   (ready),
        .rdata   (rdata),
        .err     (err),
        .bus     (bus),
        .sel_en  (sel_en),
        .rsp     (rsp),
        .miss    (miss)
    );

    apb_addr_map u_addr_map (
        .sel_en   (sel_en),
        .paddr    (bus.paddr),
        .slave_rsp(slave_rsp),
        .psel     (psel),
        .rsp      (rsp),
        .miss     (miss)
    );

    // slot n waits n cycles
    for (genvar i = 0; i < `APB_NUM_SLOTS; i++) begin : g_bank
        apb_reg_bank #(
            .WAIT_CYCLES(i)
        ) u_bank (
            .PCLK  (PCLK),
            .PRESET(PRESET),
            .psel  (psel[i]),
            .bus   (bus),
            .rsp   (slave_rsp[i])
        );
    end

endmodule

// ==== rtl/apb_reg_bank.sv ====
`timescale 1ns/1ps
`include "apb_defines.svh"

module apb_reg_bank #(
    parameter int WAIT_CYCLES = 0
) (
    input  logic              PCLK,
    input  logic              PRESET,
    input  logic              psel,
    input  apb_pkg::apb_bus_t bus,
    output apb_pkg::apb_rsp_t rsp
);
    localparam int IDX_W = $clog2(`APB_BANK_DEPTH);

    logic [`APB_DATA_W-1:0] mem [`APB_BANK_DEPTH];
    logic [IDX_W-1:0]       idx;
    logic                   access;
    logic                   timer_ready;
    logic                   wr_en;

    // word index from paddr[5:2]
    assign idx    = bus.paddr[2 +: IDX_W];
    assign access = psel && bus.penable;

    apb_wait_timer #(
        .WAIT_CYCLES(WAIT_CYCLES)
    ) u_wait_timer (
        .PCLK  (PCLK),
        .PRESET(PRESET),
        .active(access),
        .ready (timer_ready)
    );

    assign rsp.pready = access && timer_ready;
    assign wr_en      = rsp.pready && bus.pwrite;

    always_ff @(posedge PCLK or posedge PRESET) begin
        if (PRESET) begin
            for (int i = 0; i < `APB_BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[idx] <= bus.pwdata;
        end
    end

    // read path only open during ACCESS
    assign rsp.prdata = access ? mem[idx] : '0;

    a_penable_needs_setup : assert property (
        @(posedge PCLK) disable iff (PRESET)
        (psel && bus.penable) |-> $past(psel)
    ) else $error("penable seen without this slave selected in SETUP");

endmodule

// ==== rtl/apb_addr_map.sv ====
`timescale 1ns/1ps
`include "apb_defines.svh"

module apb_addr_map (
    input  logic                     sel_en,
    input  logic [`APB_ADDR_W-1:0]   paddr,
    input  apb_pkg::apb_rsp_t        slave_rsp [`APB_NUM_SLOTS],
    output logic [`APB_NUM_SLOTS-1:0] psel,
    output apb_pkg::apb_rsp_t        rsp,
    output logic                     miss
);
    localparam int SLOT_W   = $clog2(`APB_NUM_SLOTS);
    localparam int SLOT_LSB = 12;
    localparam int WIN_LSB  = SLOT_LSB + SLOT_W;
    localparam logic [`APB_ADDR_W-1:0] WIN_BASE = `APB_WIN_BASE;

    logic              in_win;
    logic [SLOT_W-1:0] slot;

    // upper bits pick the window, the 4 KB page picks the slot
    assign in_win = (paddr[`APB_ADDR_W-1:WIN_LSB] == WIN_BASE[`APB_ADDR_W-1:WIN_LSB]);
    assign slot   = paddr[SLOT_LSB +: SLOT_W];
    assign miss   = !in_win;

    always_comb begin
        psel = '0;
        if (sel_en && in_win) begin
            psel[slot] = 1'b1;
        end
    end

    always_comb begin
        if (in_win) begin
            rsp = slave_rsp[slot];
        end else begin
            // nobody answers, complete at once with no data
            rsp.prdata = '0;
            rsp.pready = 1'b1;
        end
    end

    always_comb begin
        a_psel_onehot : assert final ($onehot0(psel))
            else $error("psel has more than one bit set: %b", psel);
    end

endmodule

// ==== rtl/apb_master.sv ====
`timescale 1ns/1ps
`include "apb_defines.svh"

module apb_master (
    input  logic                   PCLK,
    input  logic                   PRESET,
    input  logic                   transfer,
    input  apb_pkg::apb_req_t      req,
    output logic                   ready,
    output logic [`APB_DATA_W-1:0] rdata,
    output logic                   err,
    output apb_pkg::apb_bus_t      bus,
    output logic                   sel_en,
    input  apb_pkg::apb_rsp_t      rsp,
    input  logic                   miss
);
    import apb_pkg::*;

    apb_state_e state;
    apb_state_e state_next;
    apb_req_t   req_q;
    logic       done;

    // last ACCESS cycle of the transfer
    assign done = (state == ACCESS) && rsp.pready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (transfer) begin
                    state_next = SETUP;
                end
            end
            SETUP: begin
                state_next = ACCESS;
            end
            ACCESS: begin
                if (rsp.pready) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge PCLK or posedge PRESET) begin
        if (PRESET) begin
            state <= IDLE;
            ready <= 1'b0;
            err   <= 1'b0;
            rdata <= '0;
        end else begin
            state <= state_next;
            ready <= done;
            if (done) begin
                // writes and misses return zero
                rdata <= (req_q.write || miss) ? '0 : rsp.prdata;
                err   <= miss;
            end
        end
    end

    // request held for the whole transfer
    always_ff @(posedge PCLK) begin
        if (state == IDLE && transfer) begin
            req_q <= req;
        end
    end

    assign bus.paddr   = req_q.addr;
    assign bus.pwdata  = req_q.wdata;
    assign bus.pwrite  = req_q.write;
    assign bus.penable = (state == ACCESS);
    assign sel_en      = (state != IDLE);

    a_penable_after_setup : assert property (
        @(posedge PCLK) disable iff (PRESET)
        $rose(bus.penable) |-> $past(state == SETUP)
    ) else $error("penable rose without a SETUP cycle before it");

    a_paddr_stable : assert property (
        @(posedge PCLK) disable iff (PRESET)
        (state == ACCESS && $past(state == ACCESS)) |-> $stable(bus.paddr)
    ) else $error("paddr changed during ACCESS");

    a_ready_pulse : assert property (
        @(posedge PCLK) disable iff (PRESET)
        ready |=> !ready
    ) else $error("ready high for more than one cycle");

endmodule

// ==== rtl/apb_wait_timer.sv ====
`timescale 1ns/1ps

module apb_wait_timer #(
    parameter int WAIT_CYCLES = 0
) (
    input  logic PCLK,
    input  logic PRESET,
    input  logic active,
    output logic ready
);
    localparam int CNT_W = 4;
    localparam logic [CNT_W-1:0] LIMIT = WAIT_CYCLES[CNT_W-1:0];

    logic [CNT_W-1:0] count;

    if (WAIT_CYCLES < 0 || WAIT_CYCLES > 15) begin : g_range_check
        $error("WAIT_CYCLES must lie in 0 to 15");
    end

    // counts ACCESS cycles, stops at the limit
    always_ff @(posedge PCLK or posedge PRESET) begin
        if (PRESET) begin
            count <= '0;
        end else if (!active) begin
            count <= '0;
        end else if (count != LIMIT) begin
            count <= count + 1'b1;
        end
    end

    // zero wait states gives ready straight away
    assign ready = (count == LIMIT);

endmodule

// ==== rtl/apb_pkg.sv ====
`include "apb_defines.svh"

package apb_pkg;

    // processor side request
    typedef struct packed {
        logic [`APB_ADDR_W-1:0] addr;
        logic [`APB_DATA_W-1:0] wdata;
        logic                   write;
    } apb_req_t;

    // master to slave, psel travels on its own
    typedef struct packed {
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`APB_DATA_W-1:0] pwdata;
        logic                   pwrite;
        logic                   penable;
    } apb_bus_t;

    // slave to master
    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pready;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_e;

endpackage

// ==== rtl/apb_defines.svh ====
`ifndef APB_DEFINES_SVH
`define APB_DEFINES_SVH

// bus widths
`define APB_ADDR_W 32
`define APB_DATA_W 32

// peripheral window, bits 31:14 must match
`define APB_WIN_BASE 32'h1000_0000

// one slot per 4 KB page inside the window
`define APB_NUM_SLOTS 4

// words per register bank, indexed by paddr[5:2]
`define APB_BANK_DEPTH 16

`endif
